/* compile.f */
verilog/flash_ctrl_pkg.sv
verilog/flash_fifo.sv
verilog/flash_bank.sv
verilog/flash_op_ctrl.sv
verilog/flash_intr.sv
verilog/flash_ctrl.sv
dv/flash_ctrl_tb.sv

/* Bender.yml */
package:
  name: flash_ctrl

sources:
  - files:
      - verilog/flash_ctrl_pkg.sv
      - verilog/flash_fifo.sv
      - verilog/flash_bank.sv
      - verilog/flash_op_ctrl.sv
      - verilog/flash_intr.sv
      - verilog/flash_ctrl.sv
  - target: test
    files:
      - dv/flash_ctrl_tb.sv

/* dv/flash_ctrl_tb.sv */
/* testbench for the flash controller
   random read, program and erase commands checked against an array model
   back-pressure, error and interrupt level checks */
`timescale 1ns/1ps

module flash_ctrl_tb;

  localparam int NumCmds     = 40;
  // an erase step is three commands and the fixed phases add eighteen more
  localparam int TotalCmds   = 3 * NumCmds + 18;
  // worst case per command is 16 words at up to 9 cycles each plus margin for pops
  localparam int WorstCmd    = 16 * 9 + 40;
  localparam int MaxCycles   = TotalCmds * WorstCmd;
  localparam int StallCycles = flash_ctrl_pkg::RdFifoDepth * (flash_ctrl_pkg::RdCycles + 2) * 2;

  logic                              clk_i;
  logic                              rst_n_i;
  logic                              op_start_i;
  flash_ctrl_pkg::op_cmd_t           op_cmd_i;
  logic                              op_busy_o;
  logic                              prog_wvalid_i;
  logic [flash_ctrl_pkg::DataW-1:0]  prog_wdata_i;
  logic                              prog_full_o;
  logic                              rd_ren_i;
  logic                              rd_rvalid_o;
  logic [flash_ctrl_pkg::DataW-1:0]  rd_rdata_o;
  logic                              intr_clr_i;
  flash_ctrl_pkg::flash_intr_t       intr_o;

  logic [31:0] lfsr_q;
  logic [31:0] model_mem [64];
  int          cycle_cnt;

  flash_ctrl dut0 (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .op_start_i    (op_start_i),
    .op_cmd_i      (op_cmd_i),
    .op_busy_o     (op_busy_o),
    .prog_wvalid_i (prog_wvalid_i),
    .prog_wdata_i  (prog_wdata_i),
    .prog_full_o   (prog_full_o),
    .rd_ren_i      (rd_ren_i),
    .rd_rvalid_o   (rd_rvalid_o),
    .rd_rdata_o    (rd_rdata_o),
    .intr_clr_i    (intr_clr_i),
    .intr_o        (intr_o)
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MaxCycles) begin
      $display("timeout: the run did not finish within %0d cycles", MaxCycles);
      $display("Test failures found");
      $fatal(1);
    end
  end

  // galois lfsr stepped once per random bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hB4BC_D35C) : (lfsr_q >> 1);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  // level interrupts against fifo counts tracked by the testbench
  task automatic check_levels(input int pcnt, input int rcnt);
    check_eq("intr_o.prog_empty", pcnt == 0, intr_o.prog_empty);
    check_eq("intr_o.prog_lvl", pcnt <= flash_ctrl_pkg::ProgLvl, intr_o.prog_lvl);
    check_eq("prog_full_o", pcnt == flash_ctrl_pkg::ProgFifoDepth, prog_full_o);
    check_eq("intr_o.rd_lvl", rcnt >= flash_ctrl_pkg::RdLvl, intr_o.rd_lvl);
    check_eq("intr_o.rd_full", rcnt == flash_ctrl_pkg::RdFifoDepth, intr_o.rd_full);
  endtask

  task automatic clear_intr();
    intr_clr_i = 1'b1;
    @(negedge clk_i);
    intr_clr_i = 1'b0;
    check_eq("intr_o.op_done", 0, intr_o.op_done);
    check_eq("intr_o.err", 0, intr_o.err);
  endtask

  task automatic wait_done();
    while (!intr_o.op_done) begin
      @(negedge clk_i);
    end
  endtask

  task automatic start_cmd(input flash_ctrl_pkg::flash_op_e op, input logic [5:0] addr,
                           input logic [3:0] cnt, input bit ok);
    op_cmd_i.op   = op;
    op_cmd_i.addr = addr;
    op_cmd_i.cnt  = cnt;
    op_start_i    = 1'b1;
    @(negedge clk_i);
    op_start_i = 1'b0;
    if (ok) begin
      check_eq("op_busy_o", 1, op_busy_o);
      check_eq("intr_o.err", 0, intr_o.err);
    end else begin
      check_eq("intr_o.err", 1, intr_o.err);
      check_eq("intr_o.op_done", 1, intr_o.op_done);
    end
  endtask

  // programming can only clear bits
  task automatic push_word(input int a);
    logic [31:0] d;
    d = rand_bits(32);
    prog_wdata_i  = d;
    prog_wvalid_i = 1'b1;
    model_mem[a]  = model_mem[a] & d;
    @(negedge clk_i);
    prog_wvalid_i = 1'b0;
  endtask

  task automatic run_read(input logic [5:0] addr, input logic [3:0] cnt, input bit hold);
    int n;
    int got;
    n   = int'(cnt) + 1;
    got = 0;
    clear_intr();
    start_cmd(flash_ctrl_pkg::OpRead, addr, cnt, 1'b1);
    // without pops the throttle stops one below full
    if (hold) begin
      repeat (StallCycles) @(negedge clk_i);
      check_eq("op_busy_o", 1, op_busy_o);
      check_eq("intr_o.op_done", 0, intr_o.op_done);
      check_levels(0, flash_ctrl_pkg::RdFifoDepth - 1);
    end
    while (got < n) begin
      if (n - got > flash_ctrl_pkg::RdFifoDepth - 1) begin
        check_eq("intr_o.op_done", 0, intr_o.op_done);
      end
      if (rd_rvalid_o && rand_bits(1)) begin
        check_eq("rd_rdata_o", model_mem[int'(addr) + got], rd_rdata_o);
        rd_ren_i = 1'b1;
        got++;
      end
      @(negedge clk_i);
      rd_ren_i = 1'b0;
    end
    wait_done();
    check_eq("op_busy_o", 0, op_busy_o);
    check_eq("rd_rvalid_o", 0, rd_rvalid_o);
  endtask

  task automatic run_prog(input logic [5:0] addr, input logic [3:0] cnt, input bit fill);
    int n;
    int pre;
    int sent;
    n    = int'(cnt) + 1;
    pre  = rand_bits(4) % 9;
    sent = 0;
    if (fill) begin
      pre = flash_ctrl_pkg::ProgFifoDepth;
    end
    if (pre > n) begin
      pre = n;
    end
    clear_intr();
    while (sent < pre) begin
      push_word(int'(addr) + sent);
      sent++;
      check_levels(sent, 0);
    end
    start_cmd(flash_ctrl_pkg::OpProg, addr, cnt, 1'b1);
    while (sent < n) begin
      if (!prog_full_o && rand_bits(1)) begin
        push_word(int'(addr) + sent);
        sent++;
      end else begin
        @(negedge clk_i);
      end
    end
    wait_done();
    check_eq("op_busy_o", 0, op_busy_o);
    check_levels(0, 0);
  endtask

  task automatic run_erase(input logic [5:0] addr);
    logic [1:0] page;
    logic [1:0] nbr;
    page = addr[5:4];
    nbr  = (page == 2'd0) ? 2'd1 : page - 2'd1;
    clear_intr();
    start_cmd(flash_ctrl_pkg::OpErase, addr, 4'(rand_bits(4)), 1'b1);
    wait_done();
    for (int i = 0; i < 16; i++) begin
      model_mem[{page, 4'(i)}] = '1;
    end
    run_read({page, 4'd0}, 4'd15, 1'b0);
    run_read({nbr, 4'd0}, 4'd15, 1'b0);
  endtask

  task automatic read_all();
    for (int p = 0; p < 4; p++) begin
      run_read(6'(p * 16), 4'd15, 1'b0);
    end
  endtask

  initial begin
    int op_sel;
    int a;
    int c;
    logic [5:0] ea;
    rst_n_i       = 1'b0;
    op_start_i    = 1'b0;
    op_cmd_i      = '0;
    prog_wvalid_i = 1'b0;
    prog_wdata_i  = '0;
    rd_ren_i      = 1'b0;
    intr_clr_i    = 1'b0;
    cycle_cnt     = 0;
    lfsr_q        = 32'd28;
    for (int i = 0; i < 64; i++) begin
      model_mem[i] = '1;
    end
    repeat (10) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);

    check_eq("op_busy_o", 0, op_busy_o);
    check_eq("rd_rvalid_o", 0, rd_rvalid_o);
    check_eq("intr_o", 32'h30, intr_o);
    read_all();

    for (int k = 0; k < NumCmds; k++) begin
      op_sel = rand_bits(2);
      a      = rand_bits(6);
      c      = rand_bits(4);
      if (a + c > 63) begin
        c = 63 - a;
      end
      case (op_sel)
        0:       run_read(6'(a), 4'(c), 1'b0);
        2:       run_erase(6'(a));
        default: run_prog(6'(a), 4'(c), 1'b0);
      endcase
    end
    read_all();

    // 16-word read against a read fifo of 8
    run_read(6'(rand_bits(4)), 4'd15, 1'b1);

    // program fifo filled before the command starts
    run_prog(6'(rand_bits(5)), 4'd15, 1'b1);

    // out of range commands
    clear_intr();
    start_cmd(flash_ctrl_pkg::OpProg, 6'd56, 4'd15, 1'b0);
    check_eq("op_busy_o", 0, op_busy_o);
    clear_intr();
    start_cmd(flash_ctrl_pkg::OpRead, 6'd63, 4'd1, 1'b0);
    clear_intr();

    // command while an erase is running
    ea = 6'(rand_bits(6));
    start_cmd(flash_ctrl_pkg::OpErase, ea, 4'd0, 1'b1);
    start_cmd(flash_ctrl_pkg::OpProg, 6'd0, 4'd0, 1'b0);
    while (op_busy_o) begin
      @(negedge clk_i);
    end
    for (int i = 0; i < 16; i++) begin
      model_mem[{ea[5:4], 4'(i)}] = '1;
    end
    clear_intr();
    check_levels(0, 0);
    read_all();

    $display("All tests passed!");
    $finish;
  end

endmodule

/* verilog/flash_ctrl.sv */
/* flash controller top level
   program and read fifos, operation sequencer, flash bank and interrupts */
`timescale 1ns/1ps

module flash_ctrl (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              op_start_i,
  input  flash_ctrl_pkg::op_cmd_t           op_cmd_i,
  output logic                              op_busy_o,
  input  logic                              prog_wvalid_i,
  input  logic [flash_ctrl_pkg::DataW-1:0]  prog_wdata_i,
  output logic                              prog_full_o,
  input  logic                              rd_ren_i,
  output logic                              rd_rvalid_o,
  output logic [flash_ctrl_pkg::DataW-1:0]  rd_rdata_o,
  input  logic                              intr_clr_i,
  output flash_ctrl_pkg::flash_intr_t       intr_o
);

  logic                             prog_pop;
  logic                             prog_empty;
  logic [flash_ctrl_pkg::DataW-1:0] prog_rdata;
  logic [flash_ctrl_pkg::CntW-1:0]  prog_count;
  logic                             rd_push;
  logic [flash_ctrl_pkg::DataW-1:0] rd_wdata;
  logic                             rd_empty;
  logic                             rd_full;
  logic [flash_ctrl_pkg::CntW-1:0]  rd_count;
  logic                             bank_req_valid;
  flash_ctrl_pkg::bank_req_t        bank_req;
  logic                             bank_done;
  logic [flash_ctrl_pkg::DataW-1:0] bank_rdata;
  logic                             op_done;
  logic                             err;

  assign rd_rvalid_o = ~rd_empty;

  flash_fifo #(
    .Depth(flash_ctrl_pkg::ProgFifoDepth)
  ) u_prog_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (prog_wvalid_i),
    .wdata_i (prog_wdata_i),
    .pop_i   (prog_pop),
    .rdata_o (prog_rdata),
    .empty_o (prog_empty),
    .full_o  (prog_full_o),
    .count_o (prog_count)
  );

  flash_fifo #(
    .Depth(flash_ctrl_pkg::RdFifoDepth)
  ) u_rd_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (rd_push),
    .wdata_i (rd_wdata),
    .pop_i   (rd_ren_i),
    .rdata_o (rd_rdata_o),
    .empty_o (rd_empty),
    .full_o  (rd_full),
    .count_o (rd_count)
  );

  flash_op_ctrl u_op_ctrl (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .op_start_i       (op_start_i),
    .op_cmd_i         (op_cmd_i),
    .op_busy_o        (op_busy_o),
    .prog_empty_i     (prog_empty),
    .prog_rdata_i     (prog_rdata),
    .prog_pop_o       (prog_pop),
    .rd_count_i       (rd_count),
    .rd_push_o        (rd_push),
    .rd_wdata_o       (rd_wdata),
    .bank_req_valid_o (bank_req_valid),
    .bank_req_o       (bank_req),
    .bank_done_i      (bank_done),
    .bank_rdata_i     (bank_rdata),
    .op_done_o        (op_done),
    .err_o            (err)
  );

  flash_bank u_bank (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (bank_req_valid),
    .req_i       (bank_req),
    .done_o      (bank_done),
    .rdata_o     (bank_rdata)
  );

  flash_intr u_intr (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .prog_count_i (prog_count),
    .prog_full_i  (prog_full_o),
    .rd_count_i   (rd_count),
    .rd_full_i    (rd_full),
    .op_done_i    (op_done),
    .err_i        (err),
    .clr_i        (intr_clr_i),
    .intr_o       (intr_o)
  );

endmodule

/* verilog/flash_intr.sv */
/* interrupt generation
   fifo level interrupts from the counts, sticky op done and error flags */
`timescale 1ns/1ps

module flash_intr (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic [flash_ctrl_pkg::CntW-1:0]  prog_count_i,
  input  logic                             prog_full_i,
  input  logic [flash_ctrl_pkg::CntW-1:0]  rd_count_i,
  input  logic                             rd_full_i,
  input  logic                             op_done_i,
  input  logic                             err_i,
  input  logic                             clr_i,
  output flash_ctrl_pkg::flash_intr_t      intr_o
);

  logic op_done_q;
  logic err_q;

  assign intr_o.prog_empty = (prog_count_i == '0);
  // a full program fifo is never at or below the low-water level
  assign intr_o.prog_lvl   = ~prog_full_i &
                             (prog_count_i <= flash_ctrl_pkg::CntW'(flash_ctrl_pkg::ProgLvl));
  assign intr_o.rd_full    = rd_full_i;
  assign intr_o.rd_lvl     = (rd_count_i >= flash_ctrl_pkg::CntW'(flash_ctrl_pkg::RdLvl));
  assign intr_o.op_done    = op_done_q;
  assign intr_o.err        = err_q;

  // set has priority over clear
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      op_done_q <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      if (op_done_i) begin
        op_done_q <= 1'b1;
      end else if (clr_i) begin
        op_done_q <= 1'b0;
      end
      if (err_i) begin
        err_q <= 1'b1;
      end else if (clr_i) begin
        err_q <= 1'b0;
      end
    end
  end

endmodule

/* verilog/flash_op_ctrl.sv */
/* operation sequencer
   checks each command, then walks it one word per bank access
   moving program data from the program fifo and read data into the read fifo */
`timescale 1ns/1ps

module flash_op_ctrl (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              op_start_i,
  input  flash_ctrl_pkg::op_cmd_t           op_cmd_i,
  output logic                              op_busy_o,
  input  logic                              prog_empty_i,
  input  logic [flash_ctrl_pkg::DataW-1:0]  prog_rdata_i,
  output logic                              prog_pop_o,
  input  logic [flash_ctrl_pkg::CntW-1:0]   rd_count_i,
  output logic                              rd_push_o,
  output logic [flash_ctrl_pkg::DataW-1:0]  rd_wdata_o,
  output logic                              bank_req_valid_o,
  output flash_ctrl_pkg::bank_req_t         bank_req_o,
  input  logic                              bank_done_i,
  input  logic [flash_ctrl_pkg::DataW-1:0]  bank_rdata_i,
  output logic                              op_done_o,
  output logic                              err_o
);

  typedef enum logic [1:0] {
    StIdle,
    StIssue,
    StWait
  } state_e;

  state_e                              state_q;
  flash_ctrl_pkg::flash_op_e           op_q;
  logic [flash_ctrl_pkg::AddrW-1:0]    addr_q;
  logic [flash_ctrl_pkg::WordCntW-1:0] remain_q;
  logic [flash_ctrl_pkg::AddrW:0]      end_addr;
  logic                                cmd_bad;
  logic                                accept;
  logic                                reject;
  logic                                can_issue;
  logic                                word_done;
  logic                                last_word;

  // erase ignores the count, so only reads and programs can run off the end
  assign end_addr = {1'b0, op_cmd_i.addr} + (flash_ctrl_pkg::AddrW + 1)'(op_cmd_i.cnt);
  always_comb begin
    case (op_cmd_i.op)
      flash_ctrl_pkg::OpRead,
      flash_ctrl_pkg::OpProg:  cmd_bad = end_addr[flash_ctrl_pkg::AddrW];
      flash_ctrl_pkg::OpErase: cmd_bad = 1'b0;
      default:                 cmd_bad = 1'b1;
    endcase
  end

  assign accept = op_start_i & (state_q == StIdle) & ~cmd_bad;
  assign reject = op_start_i & ((state_q != StIdle) | cmd_bad);

  // read throttle leaves room for the word already in flight
  always_comb begin
    case (op_q)
      flash_ctrl_pkg::OpRead:
        can_issue = rd_count_i < flash_ctrl_pkg::CntW'(flash_ctrl_pkg::RdFifoDepth - 1);
      flash_ctrl_pkg::OpProg:
        can_issue = ~prog_empty_i;
      default:
        can_issue = 1'b1;
    endcase
  end

  assign bank_req_valid_o = (state_q == StIssue) & can_issue;
  assign bank_req_o.op    = op_q;
  assign bank_req_o.addr  = addr_q;
  assign bank_req_o.wdata = prog_rdata_i;
  assign prog_pop_o       = bank_req_valid_o & (op_q == flash_ctrl_pkg::OpProg);

  assign word_done  = (state_q == StWait) & bank_done_i;
  assign last_word  = (remain_q == '0);
  assign rd_push_o  = word_done & (op_q == flash_ctrl_pkg::OpRead);
  assign rd_wdata_o = bank_rdata_i;

  assign op_busy_o = (state_q != StIdle);
  assign op_done_o = reject | (word_done & last_word);
  assign err_o     = reject;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= StIdle;
      op_q     <= flash_ctrl_pkg::OpRead;
      addr_q   <= '0;
      remain_q <= '0;
    end else begin
      case (state_q)
        StIdle: begin
          if (accept) begin
            state_q <= StIssue;
            op_q    <= op_cmd_i.op;
            addr_q  <= op_cmd_i.addr;
            // a page erase is a single bank access
            remain_q <= (op_cmd_i.op == flash_ctrl_pkg::OpErase) ? '0 : op_cmd_i.cnt;
          end
        end
        StIssue: begin
          if (can_issue) begin
            state_q <= StWait;
          end
        end
        StWait: begin
          if (bank_done_i) begin
            if (last_word) begin
              state_q <= StIdle;
            end else begin
              state_q  <= StIssue;
              addr_q   <= addr_q + 1'b1;
              remain_q <= remain_q - 1'b1;
            end
          end
        end
        default: state_q <= StIdle;
      endcase
    end
  end

endmodule

/* verilog/flash_bank.sv */
/* behavioral single-bank flash array
   program can only clear bits, erase sets a page to ones
   each access completes after a fixed latency with a done pulse */
`timescale 1ns/1ps

module flash_bank (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              req_valid_i,
  input  flash_ctrl_pkg::bank_req_t         req_i,
  output logic                              done_o,
  output logic [flash_ctrl_pkg::DataW-1:0]  rdata_o
);

  localparam int unsigned Words = 2 ** flash_ctrl_pkg::AddrW;

  logic [flash_ctrl_pkg::DataW-1:0] mem [Words];
  flash_ctrl_pkg::bank_req_t        req_q;
  logic [flash_ctrl_pkg::LatW-1:0]  lat_cnt_q;
  logic [flash_ctrl_pkg::LatW-1:0]  lat_load;
  logic [flash_ctrl_pkg::AddrW-flash_ctrl_pkg::PageW-1:0] page;

  // counter starts one below the latency so done lands on the latency cycle
  always_comb begin
    case (req_i.op)
      flash_ctrl_pkg::OpRead:  lat_load = flash_ctrl_pkg::LatW'(flash_ctrl_pkg::RdCycles - 1);
      flash_ctrl_pkg::OpProg:  lat_load = flash_ctrl_pkg::LatW'(flash_ctrl_pkg::ProgCycles - 1);
      default: lat_load = flash_ctrl_pkg::LatW'(flash_ctrl_pkg::EraseCycles - 1);
    endcase
  end

  assign page = req_q.addr[flash_ctrl_pkg::AddrW-1:flash_ctrl_pkg::PageW];

  always_ff @(posedge clk_i) begin
    if (req_valid_i && lat_cnt_q == '0) begin
      req_q <= req_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lat_cnt_q <= '0;
      done_o    <= 1'b0;
      rdata_o   <= '0;
      for (int i = 0; i < Words; i++) begin
        mem[i] <= '1;
      end
    end else begin
      done_o <= 1'b0;
      if (lat_cnt_q == '0) begin
        if (req_valid_i) begin
          lat_cnt_q <= lat_load;
        end
      end else begin
        lat_cnt_q <= lat_cnt_q - 1'b1;
        if (lat_cnt_q == flash_ctrl_pkg::LatW'(1)) begin
          done_o <= 1'b1;
          case (req_q.op)
            flash_ctrl_pkg::OpRead: rdata_o <= mem[req_q.addr];
            flash_ctrl_pkg::OpProg: mem[req_q.addr] <= mem[req_q.addr] & req_q.wdata;
            default: begin
              for (int i = 0; i < flash_ctrl_pkg::PageWords; i++) begin
                mem[{page, flash_ctrl_pkg::PageW'(i)}] <= '1;
              end
            end
          endcase
        end
      end
    end
  end

endmodule

/* verilog/flash_fifo.sv */
/* synchronous register-array fifo with occupancy count
   show-ahead read port, pushes when full and pops when empty are dropped */
`timescale 1ns/1ps

module flash_fifo #(
  parameter int unsigned Depth = 8
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                push_i,
  input  logic [flash_ctrl_pkg::DataW-1:0]    wdata_i,
  input  logic                                pop_i,
  output logic [flash_ctrl_pkg::DataW-1:0]    rdata_o,
  output logic                                empty_o,
  output logic                                full_o,
  output logic [flash_ctrl_pkg::CntW-1:0]     count_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;

  logic [flash_ctrl_pkg::DataW-1:0] mem [Depth];
  logic [PtrW-1:0]                  wptr_q;
  logic [PtrW-1:0]                  rptr_q;
  logic [flash_ctrl_pkg::CntW-1:0]  count_q;
  logic                             do_push;
  logic                             do_pop;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == flash_ctrl_pkg::CntW'(Depth));
  assign count_o = count_q;
  assign rdata_o = mem[rptr_q];

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // storage has no reset, only the pointers and count
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (do_push) begin
        wptr_q <= (wptr_q == PtrW'(Depth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (do_pop) begin
        rptr_q <= (rptr_q == PtrW'(Depth - 1)) ? '0 : rptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

/* verilog/flash_ctrl_pkg.sv */
/* flash controller shared definitions
   sizes, fifo levels and bank access latencies
   operation codes and the command, bank request and interrupt structs */
package flash_ctrl_pkg;

  // array geometry
  localparam int unsigned DataW     = 32;
  localparam int unsigned AddrW     = 6;
  localparam int unsigned PageWords = 16;
  localparam int unsigned PageW     = $clog2(PageWords);
  localparam int unsigned WordCntW  = 4;

  // fifo sizing and interrupt levels
  localparam int unsigned ProgFifoDepth = 8;
  localparam int unsigned RdFifoDepth   = 8;
  localparam int unsigned CntW          = 4;
  localparam int unsigned ProgLvl       = 2;
  localparam int unsigned RdLvl         = 4;

  // bank latencies in cycles from request strobe to done pulse
  localparam int unsigned RdCycles    = 2;
  localparam int unsigned ProgCycles  = 3;
  localparam int unsigned EraseCycles = 8;
  localparam int unsigned LatW        = 4;

  typedef enum logic [1:0] {
    OpRead  = 2'd0,
    OpProg  = 2'd1,
    OpErase = 2'd2
  } flash_op_e;

  // cnt holds the number of words minus one
  typedef struct packed {
    flash_op_e             op;
    logic [AddrW-1:0]      addr;
    logic [WordCntW-1:0]   cnt;
  } op_cmd_t;

  typedef struct packed {
    flash_op_e          op;
    logic [AddrW-1:0]   addr;
    logic [DataW-1:0]   wdata;
  } bank_req_t;

  typedef struct packed {
    logic prog_empty;
    logic prog_lvl;
    logic rd_full;
    logic rd_lvl;
    logic op_done;
    logic err;
  } flash_intr_t;

endpackage
